// File: side_ch.f
src/side_ch_pkg.sv
src/side_ch_cfg_if.sv
src/side_ch_reg_bank.sv
src/side_ch_event_counters.sv
src/side_ch_iq_capture.sv
src/side_ch_stream_fifo.sv
src/side_ch.sv
bench/tb_side_ch.sv

// File: Makefile
VERILATOR := verilator
TOP       := tb_side_ch
FILELIST  := side_ch.f
BUILD_DIR := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
LINTFLAGS := --lint-only -Wall --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_side_ch.sv
// side channel testbench with a stimulus table, a reference model and self checks
`timescale 1ns/1ps

module tb_side_ch import side_ch_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int DRAIN_EST  = 80;
	localparam logic [31:0] SEED = 32'h2aee;

	localparam logic [2:0] OP_WR    = 3'd0;
	localparam logic [2:0] OP_RD    = 3'd1;
	localparam logic [2:0] OP_EVT   = 3'd2;
	localparam logic [2:0] OP_CLRX  = 3'd3;
	localparam logic [2:0] OP_SAMP  = 3'd4;
	localparam logic [2:0] OP_DRAIN = 3'd5;

	// trigger condition produced during a sample burst
	localparam logic [1:0] COND_NONE = 2'd0;
	localparam logic [1:0] COND_RSSI = 2'd1;
	localparam logic [1:0] COND_FCS  = 2'd2;

	localparam logic signed [RSSI_W-1:0] RSSI_IDLE = -11'sd1000;

	localparam int ST_IDLE  = 0;
	localparam int ST_ARMED = 1;
	localparam int ST_RUN   = 2;

	typedef struct packed {
		logic [2:0]  op;
		logic [3:0]  addr;
		logic [31:0] data;
		logic [15:0] n;
		logic [1:0]  cond;
		logic [7:0]  arg;
		logic [1:0]  tr;
	} row_t;

	logic clk;
	logic arst_n;
	logic reg_wr;
	logic reg_rd;
	logic [REG_ADDR_W-1:0] reg_addr;
	logic [REG_DATA_W-1:0] reg_wdata;
	logic [REG_DATA_W-1:0] reg_rdata;
	logic reg_rvalid;
	logic short_preamble_detected;
	logic long_preamble_detected;
	logic pkt_header_valid_strobe;
	logic pkt_header_valid;
	logic fcs_in_strobe;
	logic fcs_ok;
	logic phy_tx_start;
	logic phy_tx_done;
	logic tx_pkt_need_ack;
	logic pkt_for_me;
	logic [ADDR2_W-1:0] addr2;
	logic signed [RSSI_W-1:0] rssi_half_db;
	logic [2*IQ_W-1:0] sample0_in;
	logic [2*IQ_W-1:0] sample1_in;
	logic sample_in_strobe;
	logic m_axis_tvalid;
	logic [STREAM_W-1:0] m_axis_tdata;
	logic m_axis_tlast;
	logic m_axis_tready;

	// reference model state
	logic [TRIG_W-1:0] m_trig_sel;
	logic signed [RSSI_W-1:0] m_rssi_th;
	logic [CAP_LEN_W-1:0] m_cap_len;
	logic [NUM_EVENTS-1:0] m_event_sel;
	logic [31:0] m_addr2_target;
	logic [COUNTER_W-1:0] m_cnt [NUM_EVENTS];
	logic [31:0] m_drop;
	logic [NUM_EVENTS-1:0] m_clr_pend;
	logic m_arm_pend;
	logic m_above_d;
	int m_state;
	int m_remaining;
	logic m_fcs_seen;
	logic m_cap_pend;
	logic [STREAM_W:0] m_cap_pend_word;
	logic [STREAM_W:0] m_fifo [$];
	logic m_rd_pend;
	logic [3:0] m_rd_addr;
	logic [31:0] m_rd_exp;

	row_t rows [$];
	int err_cnt;
	int chk_cnt;
	int cycle_cnt;
	int cycle_limit;

	side_ch i_side_ch (.*);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// limit scaled from the table length
	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if ((cycle_limit > 0) && (cycle_cnt >= cycle_limit))
		begin
			$display("error: timeout after %0d cycles, the run did not finish", cycle_cnt);
			$display("Simulation FAILED");
			$finish;
		end
	end

	task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
		chk_cnt++;
		if (got !== exp)
		begin
			$display("mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
			err_cnt++;
		end
	endtask

	task automatic add_row(input logic [2:0] op, input logic [3:0] addr, input logic [31:0] data,
		input int n, input logic [1:0] cond, input int arg, input int tr);
		rows.push_back(row_t'{op, addr, data, 16'(n), cond, 8'(arg), 2'(tr)});
	endtask

	task automatic add_write(input logic [3:0] addr, input logic [31:0] data);
		add_row(OP_WR, addr, data, 1, COND_NONE, 0, 1);
	endtask

	task automatic add_read(input logic [3:0] addr);
		add_row(OP_RD, addr, 32'd0, 1, COND_NONE, 0, 1);
	endtask

	task automatic add_counter_reads();
		for (int i = 0; i < NUM_EVENTS; i++)
		begin
			add_read(REG_CNT_BASE + 4'(i));
		end
	endtask

	task automatic build_table();
		// register readback over the whole map
		add_write(REG_TRIG_SEL, 32'hffff_fffe);
		add_write(REG_RSSI_TH, 32'h0000_07f5);
		add_write(REG_CAP_LEN, 32'h0000_015a);
		add_write(REG_EVENT_SEL, 32'h0000_00ea);
		add_write(REG_ADDR2_TARGET, 32'h5c3a_e219);
		add_write(4'd6, 32'h0000_ffff);
		for (int a = 0; a < 16; a++)
		begin
			add_read(4'(a));
		end
		// event counting under both selections, then clears
		add_write(REG_RSSI_TH, 32'd20);
		add_write(REG_EVENT_SEL, 32'h0);
		add_row(OP_EVT, 4'd0, 32'd0, 150, COND_NONE, 0, 1);
		add_counter_reads();
		add_write(REG_EVENT_SEL, 32'h3f);
		add_row(OP_EVT, 4'd0, 32'd0, 150, COND_NONE, 0, 1);
		add_counter_reads();
		add_write(REG_CNT_BASE + 4'd2, 32'd0);
		add_row(OP_CLRX, REG_CNT_BASE + 4'd4, 32'd0, 2, COND_NONE, 0, 1);
		add_write(REG_EVENT_SEL, 32'h0);
		add_row(OP_CLRX, REG_CNT_BASE, 32'd0, 2, COND_NONE, 0, 1);
		add_counter_reads();
		// free run, then a zero length arm
		add_write(REG_TRIG_SEL, 32'd0);
		add_write(REG_CAP_LEN, 32'd7);
		add_write(REG_ARM, 32'd1);
		add_row(OP_SAMP, 4'd0, 32'd0, 10, COND_NONE, 0, 1);
		add_row(OP_DRAIN, 4'd0, 32'd0, 1, COND_NONE, 0, 1);
		add_write(REG_CAP_LEN, 32'd0);
		add_write(REG_ARM, 32'd1);
		add_row(OP_SAMP, 4'd0, 32'd0, 4, COND_NONE, 0, 1);
		add_row(OP_DRAIN, 4'd0, 32'd0, 1, COND_NONE, 0, 1);
		// rssi and fcs triggers
		add_write(REG_RSSI_TH, 32'd100);
		add_write(REG_TRIG_SEL, 32'd1);
		add_write(REG_CAP_LEN, 32'd5);
		add_write(REG_ARM, 32'd1);
		add_row(OP_SAMP, 4'd0, 32'd0, 10, COND_RSSI, 4, 1);
		add_row(OP_DRAIN, 4'd0, 32'd0, 1, COND_NONE, 0, 1);
		add_write(REG_TRIG_SEL, 32'd2);
		add_write(REG_CAP_LEN, 32'd4);
		add_write(REG_ARM, 32'd1);
		add_row(OP_SAMP, 4'd0, 32'd0, 10, COND_FCS, 3, 1);
		add_row(OP_DRAIN, 4'd0, 32'd0, 1, COND_NONE, 0, 1);
		// 20 words into a stalled stream
		add_write(REG_TRIG_SEL, 32'd0);
		add_write(REG_CAP_LEN, 32'd20);
		add_write(REG_ARM, 32'd1);
		add_row(OP_SAMP, 4'd0, 32'd0, 24, COND_NONE, 0, 0);
		add_read(REG_DROP_CNT);
		add_row(OP_DRAIN, 4'd0, 32'd0, 1, COND_NONE, 0, 1);
		// random ready gaps
		add_write(REG_CAP_LEN, 32'd12);
		add_write(REG_ARM, 32'd1);
		add_row(OP_SAMP, 4'd0, 32'd0, 14, COND_NONE, 0, 2);
		add_row(OP_DRAIN, 4'd0, 32'd0, 1, COND_NONE, 0, 2);
		add_read(REG_DROP_CNT);
		add_counter_reads();
	endtask

	function automatic int table_cycles();
		int total = 0;
		foreach (rows[i])
		begin
			case (rows[i].op)
				OP_EVT:   total += int'(rows[i].n);
				OP_SAMP:  total += 2 * int'(rows[i].n);
				OP_DRAIN: total += DRAIN_EST;
				OP_CLRX:  total += 2;
				default:  total += 1;
			endcase
		end
		return total;
	endfunction

	task automatic model_reset();
		m_trig_sel = '0;
		m_rssi_th = '0;
		m_cap_len = '0;
		m_event_sel = '0;
		m_addr2_target = '0;
		m_drop = '0;
		m_clr_pend = '0;
		m_arm_pend = 1'b0;
		m_above_d = 1'b0;
		m_state = ST_IDLE;
		m_remaining = 0;
		m_fcs_seen = 1'b0;
		m_cap_pend = 1'b0;
		m_cap_pend_word = '0;
		m_rd_pend = 1'b0;
		m_rd_addr = '0;
		m_rd_exp = '0;
		for (int i = 0; i < NUM_EVENTS; i++)
		begin
			m_cnt[i] = '0;
		end
	endtask

	function automatic logic [31:0] model_read(input logic [3:0] addr);
		case (addr)
			REG_TRIG_SEL:     return 32'(m_trig_sel);
			REG_RSSI_TH:      return {21'd0, m_rssi_th};
			REG_CAP_LEN:      return 32'(m_cap_len);
			REG_EVENT_SEL:    return 32'(m_event_sel);
			REG_ADDR2_TARGET: return m_addr2_target;
			REG_DROP_CNT:     return m_drop;
			default:
			begin
				if ((addr >= REG_CNT_BASE) && (addr < REG_CNT_BASE + 4'd6))
					return 32'(m_cnt[int'(addr - REG_CNT_BASE)]);
				return 32'd0;
			end
		endcase
	endfunction

	function automatic logic [NUM_EVENTS-1:0] selected_events(input logic above);
		logic [NUM_EVENTS-1:0] ev;
		logic fcs_good;
		fcs_good = fcs_in_strobe && fcs_ok;
		ev[0] = m_event_sel[0] ? long_preamble_detected : short_preamble_detected;
		ev[1] = pkt_header_valid_strobe && (pkt_header_valid != m_event_sel[1]);
		ev[2] = fcs_in_strobe && (fcs_ok != m_event_sel[2]);
		ev[3] = m_event_sel[3] ? phy_tx_done : phy_tx_start;
		ev[4] = fcs_good && (m_event_sel[4] ? pkt_for_me : (addr2[31:0] == m_addr2_target));
		ev[5] = m_event_sel[5] ? (phy_tx_start && tx_pkt_need_ack) : (above && !m_above_d);
		return ev;
	endfunction

	// one clock of the reference model on the inputs driven for this cycle
	task automatic model_step();
		logic [NUM_EVENTS-1:0] ev;
		logic above;
		logic trig;
		logic take;
		logic last;
		logic full;
		logic [STREAM_W-1:0] word;
		m_rd_pend = reg_rd;
		m_rd_addr = reg_addr;
		if (reg_rd)
			m_rd_exp = model_read(reg_addr);
		above = rssi_half_db > m_rssi_th;
		ev = selected_events(above);
		for (int i = 0; i < NUM_EVENTS; i++)
		begin
			if (m_clr_pend[i])
				m_cnt[i] = '0;
			else if (ev[i])
				m_cnt[i] = m_cnt[i] + 16'd1;
		end
		trig = 1'b0;
		take = 1'b0;
		if (m_state == ST_ARMED)
		begin
			case (m_trig_sel)
				TRIG_RSSI:   trig = above;
				TRIG_FCS_OK: trig = m_fcs_seen;
				default:     trig = 1'b1;
			endcase
			take = sample_in_strobe && trig;
			if (fcs_in_strobe && fcs_ok)
				m_fcs_seen = 1'b1;
		end
		else if (m_state == ST_RUN)
			take = sample_in_strobe;
		else if (m_arm_pend && (m_cap_len != '0))
		begin
			m_state = ST_ARMED;
			m_remaining = int'(m_cap_len);
			m_fcs_seen = 1'b0;
		end
		last = take && (m_remaining == 1);
		word = {sample1_in[15:0], sample1_in[31:16], sample0_in[15:0], sample0_in[31:16]};
		if (take)
		begin
			m_remaining--;
			m_state = last ? ST_IDLE : ST_RUN;
		end
		// transfers follow the DUT handshake
		full = (m_fifo.size() == FIFO_DEPTH);
		if (m_axis_tvalid && m_axis_tready)
		begin
			if (m_fifo.size() == 0)
			begin
				$display("error at %0t: stream word arrived with no word expected", $time);
				err_cnt++;
			end
			else
			begin
				check(m_axis_tdata, m_fifo[0][STREAM_W-1:0], "stream data");
				check(64'(m_axis_tlast), 64'(m_fifo[0][STREAM_W]), "stream last");
				void'(m_fifo.pop_front());
			end
		end
		if (m_cap_pend)
		begin
			if (full)
				m_drop = m_drop + 32'd1;
			else
				m_fifo.push_back(m_cap_pend_word);
		end
		m_cap_pend = take;
		m_cap_pend_word = {last, word};
		m_clr_pend = '0;
		m_arm_pend = 1'b0;
		if (reg_wr)
		begin
			case (reg_addr)
				REG_TRIG_SEL:     m_trig_sel = reg_wdata[TRIG_W-1:0];
				REG_RSSI_TH:      m_rssi_th = $signed(reg_wdata[RSSI_W-1:0]);
				REG_CAP_LEN:      m_cap_len = reg_wdata[CAP_LEN_W-1:0];
				REG_EVENT_SEL:    m_event_sel = reg_wdata[NUM_EVENTS-1:0];
				REG_ADDR2_TARGET: m_addr2_target = reg_wdata;
				REG_ARM:          m_arm_pend = 1'b1;
				default:          ;
			endcase
			if ((reg_addr >= REG_CNT_BASE) && (reg_addr < REG_CNT_BASE + 4'd6))
				m_clr_pend[int'(reg_addr - REG_CNT_BASE)] = 1'b1;
		end
		m_above_d = above;
	endtask

	task automatic apply_cycle();
		model_step();
		@(posedge clk);
		#1;
		check(64'(reg_rvalid), 64'(m_rd_pend), "reg_rvalid");
		if (m_rd_pend)
			check(64'(reg_rdata), 64'(m_rd_exp), $sformatf("reg_rdata at address %0d", m_rd_addr));
	endtask

	task automatic idle_inputs();
		reg_wr = 1'b0;
		reg_rd = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		short_preamble_detected = 1'b0;
		long_preamble_detected = 1'b0;
		pkt_header_valid_strobe = 1'b0;
		pkt_header_valid = 1'b0;
		fcs_in_strobe = 1'b0;
		fcs_ok = 1'b0;
		phy_tx_start = 1'b0;
		phy_tx_done = 1'b0;
		tx_pkt_need_ack = 1'b0;
		pkt_for_me = 1'b0;
		addr2 = '0;
		rssi_half_db = RSSI_IDLE;
		sample0_in = '0;
		sample1_in = '0;
		sample_in_strobe = 1'b0;
	endtask

	task automatic random_events();
		int r;
		short_preamble_detected = 1'($urandom % 2);
		long_preamble_detected = 1'($urandom % 2);
		pkt_header_valid_strobe = 1'($urandom % 2);
		pkt_header_valid = 1'($urandom % 2);
		fcs_in_strobe = 1'($urandom % 2);
		fcs_ok = 1'($urandom % 2);
		phy_tx_start = 1'($urandom % 2);
		phy_tx_done = 1'($urandom % 2);
		tx_pkt_need_ack = 1'($urandom % 2);
		pkt_for_me = 1'($urandom % 2);
		// half the cycles carry a matching addr2
		addr2 = {16'($urandom), (($urandom % 2) != 0) ? m_addr2_target : $urandom};
		r = int'(m_rssi_th) + int'($urandom % 9) - 4;
		rssi_half_db = r[RSSI_W-1:0];
	endtask

	task automatic all_events();
		short_preamble_detected = 1'b1;
		long_preamble_detected = 1'b1;
		pkt_header_valid_strobe = 1'b1;
		pkt_header_valid = 1'b1;
		fcs_in_strobe = 1'b1;
		fcs_ok = 1'b1;
		phy_tx_start = 1'b1;
		phy_tx_done = 1'b1;
		tx_pkt_need_ack = 1'b1;
		pkt_for_me = 1'b1;
	endtask

	task automatic drive_ready(input logic [1:0] tr);
		case (tr)
			2'd0:    m_axis_tready = 1'b0;
			2'd1:    m_axis_tready = 1'b1;
			default: m_axis_tready = 1'($urandom % 2);
		endcase
	endtask

	task automatic run_row(input row_t r);
		case (r.op)
			OP_WR:
			begin
				reg_wr = 1'b1;
				reg_addr = r.addr;
				reg_wdata = r.data;
				apply_cycle();
			end
			OP_RD:
			begin
				reg_rd = 1'b1;
				reg_addr = r.addr;
				apply_cycle();
			end
			OP_EVT:
			begin
				for (int k = 0; k < int'(r.n); k++)
				begin
					random_events();
					apply_cycle();
				end
			end
			OP_CLRX:
			begin
				// every event fires in the cycle of the clear pulse
				reg_wr = 1'b1;
				reg_addr = r.addr;
				apply_cycle();
				idle_inputs();
				all_events();
				apply_cycle();
			end
			OP_SAMP:
			begin
				for (int k = 0; k < int'(r.n); k++)
				begin
					for (int ph = 0; ph < 2; ph++)
					begin
						if (ph == 0)
						begin
							sample_in_strobe = 1'b1;
							sample0_in = $urandom;
							sample1_in = $urandom;
							if ((r.cond == COND_FCS) && (k == int'(r.arg)))
							begin
								fcs_in_strobe = 1'b1;
								fcs_ok = 1'b1;
							end
						end
						if ((r.cond == COND_RSSI) && (k >= int'(r.arg)))
							rssi_half_db = m_rssi_th + 11'sd3;
						drive_ready(r.tr);
						apply_cycle();
						idle_inputs();
					end
				end
			end
			OP_DRAIN:
			begin
				while ((m_fifo.size() != 0) || (m_state != ST_IDLE) || m_cap_pend)
				begin
					drive_ready(r.tr);
					apply_cycle();
				end
				// any further word is unexpected
				for (int k = 0; k < 2; k++)
				begin
					m_axis_tready = 1'b1;
					apply_cycle();
				end
			end
			default: ;
		endcase
		idle_inputs();
	endtask

	initial
	begin
		void'($urandom(SEED));
		err_cnt = 0;
		chk_cnt = 0;
		cycle_cnt = 0;
		cycle_limit = 0;
		arst_n = 1'b0;
		m_axis_tready = 1'b1;
		idle_inputs();
		model_reset();
		build_table();
		cycle_limit = 4 * table_cycles();
		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;
		foreach (rows[i])
		begin
			run_row(rows[i]);
		end
		$display("checks %0d, errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: src/side_ch.sv
// side channel top level joining register bank, event counters, iq capture and stream fifo
`timescale 1ns/1ps

module side_ch import side_ch_pkg::*;
(
	input  logic                     clk,
	input  logic                     arst_n,
	// register port
	input  logic                     reg_wr,
	input  logic                     reg_rd,
	input  logic [REG_ADDR_W-1:0]    reg_addr,
	input  logic [REG_DATA_W-1:0]    reg_wdata,
	output logic [REG_DATA_W-1:0]    reg_rdata,
	output logic                     reg_rvalid,
	// rx and tx events
	input  logic                     short_preamble_detected,
	input  logic                     long_preamble_detected,
	input  logic                     pkt_header_valid_strobe,
	input  logic                     pkt_header_valid,
	input  logic                     fcs_in_strobe,
	input  logic                     fcs_ok,
	input  logic                     phy_tx_start,
	input  logic                     phy_tx_done,
	input  logic                     tx_pkt_need_ack,
	input  logic                     pkt_for_me,
	input  logic [ADDR2_W-1:0]       addr2,
	input  logic signed [RSSI_W-1:0] rssi_half_db,
	// iq samples
	input  logic [2*IQ_W-1:0]        sample0_in,
	input  logic [2*IQ_W-1:0]        sample1_in,
	input  logic                     sample_in_strobe,
	// sample stream
	output logic                     m_axis_tvalid,
	output logic [STREAM_W-1:0]      m_axis_tdata,
	output logic                     m_axis_tlast,
	input  logic                     m_axis_tready
);

	counter_arr_t          counters;
	logic [REG_DATA_W-1:0] drop_cnt;
	logic [STREAM_W-1:0]   cap_word;
	logic                  cap_valid;
	logic                  cap_last;

	side_ch_cfg_if i_cfg_if ();

	side_ch_reg_bank i_reg_bank (
		.clk        (clk),
		.arst_n     (arst_n),
		.reg_wr     (reg_wr),
		.reg_rd     (reg_rd),
		.reg_addr   (reg_addr),
		.reg_wdata  (reg_wdata),
		.counters   (counters),
		.drop_cnt   (drop_cnt),
		.reg_rdata  (reg_rdata),
		.reg_rvalid (reg_rvalid),
		.cfg        (i_cfg_if.bank)
	);

	side_ch_event_counters i_event_counters (
		.clk                     (clk),
		.arst_n                  (arst_n),
		.short_preamble_detected (short_preamble_detected),
		.long_preamble_detected  (long_preamble_detected),
		.pkt_header_valid_strobe (pkt_header_valid_strobe),
		.pkt_header_valid        (pkt_header_valid),
		.fcs_in_strobe           (fcs_in_strobe),
		.fcs_ok                  (fcs_ok),
		.phy_tx_start            (phy_tx_start),
		.phy_tx_done             (phy_tx_done),
		.tx_pkt_need_ack         (tx_pkt_need_ack),
		.pkt_for_me              (pkt_for_me),
		.addr2                   (addr2),
		.rssi_half_db            (rssi_half_db),
		.counters                (counters),
		.cfg                     (i_cfg_if.counters)
	);

	side_ch_iq_capture i_iq_capture (
		.clk              (clk),
		.arst_n           (arst_n),
		.sample0_in       (sample0_in),
		.sample1_in       (sample1_in),
		.sample_in_strobe (sample_in_strobe),
		.rssi_half_db     (rssi_half_db),
		.fcs_in_strobe    (fcs_in_strobe),
		.fcs_ok           (fcs_ok),
		.cap_word         (cap_word),
		.cap_valid        (cap_valid),
		.cap_last         (cap_last),
		.cfg              (i_cfg_if.capture)
	);

	side_ch_stream_fifo i_stream_fifo (
		.clk           (clk),
		.arst_n        (arst_n),
		.cap_word      (cap_word),
		.cap_valid     (cap_valid),
		.cap_last      (cap_last),
		.m_axis_tready (m_axis_tready),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tlast  (m_axis_tlast),
		.drop_cnt      (drop_cnt)
	);

endmodule

// File: src/side_ch_stream_fifo.sv
// side channel show-ahead output fifo driving the sample stream and counting drops
`timescale 1ns/1ps

module side_ch_stream_fifo import side_ch_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [STREAM_W-1:0]   cap_word,
	input  logic                  cap_valid,
	input  logic                  cap_last,
	input  logic                  m_axis_tready,
	output logic                  m_axis_tvalid,
	output logic [STREAM_W-1:0]   m_axis_tdata,
	output logic                  m_axis_tlast,
	output logic [REG_DATA_W-1:0] drop_cnt
);

	// data word plus last flag in the top bit
	logic [STREAM_W:0]  mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;
	logic               full;
	logic               push;
	logic               pop;

	assign full = (count == (FIFO_AW+1)'(FIFO_DEPTH));
	// a full fifo refuses the word even if a pop happens the same cycle
	assign push = cap_valid && !full;
	assign pop  = m_axis_tvalid && m_axis_tready;

	assign m_axis_tvalid = (count != '0);
	assign m_axis_tdata  = mem[rd_ptr][STREAM_W-1:0];
	assign m_axis_tlast  = m_axis_tvalid && mem[rd_ptr][STREAM_W];

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= {cap_last, cap_word};
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			drop_cnt <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + FIFO_AW'(1);
			if (pop)
				rd_ptr <= rd_ptr + FIFO_AW'(1);
			case ({push, pop})
				2'b10:   count <= count + (FIFO_AW+1)'(1);
				2'b01:   count <= count - (FIFO_AW+1)'(1);
				default: count <= count;
			endcase
			if (cap_valid && full)
				drop_cnt <= drop_cnt + REG_DATA_W'(1);
		end
	end

endmodule

// File: src/side_ch_iq_capture.sv
// side channel iq capture with trigger qualification, length count and word packing
`timescale 1ns/1ps

module side_ch_iq_capture import side_ch_pkg::*;
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic [2*IQ_W-1:0]        sample0_in,
	input  logic [2*IQ_W-1:0]        sample1_in,
	input  logic                     sample_in_strobe,
	input  logic signed [RSSI_W-1:0] rssi_half_db,
	input  logic                     fcs_in_strobe,
	input  logic                     fcs_ok,
	output logic [STREAM_W-1:0]      cap_word,
	output logic                     cap_valid,
	output logic                     cap_last,
	side_ch_cfg_if.capture           cfg
);

	logic [CAP_STATE_W-1:0] state;
	logic [CAP_LEN_W-1:0]   remaining;
	logic                   fcs_seen;
	logic                   trig_hit;
	logic                   take;
	iq_sample_u             s0_in;
	iq_sample_u             s1_in;
	iq_sample_u             s0_sw;
	iq_sample_u             s1_sw;

	// each channel goes out with its halves swapped
	always_comb
	begin
		s0_in.raw     = sample0_in;
		s1_in.raw     = sample1_in;
		s0_sw.part.hi = s0_in.part.lo;
		s0_sw.part.lo = s0_in.part.hi;
		s1_sw.part.hi = s1_in.part.lo;
		s1_sw.part.lo = s1_in.part.hi;
	end

	always_comb
	begin
		case (cfg.trig_sel)
			TRIG_RSSI:   trig_hit = sample_in_strobe && (rssi_half_db > cfg.rssi_th);
			// fcs_seen is registered, so only samples after the fcs strobe qualify
			TRIG_FCS_OK: trig_hit = sample_in_strobe && fcs_seen;
			default:     trig_hit = sample_in_strobe;
		endcase
	end

	assign take = ((state == CAP_ARMED) && trig_hit) || ((state == CAP_RUN) && sample_in_strobe);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state     <= CAP_IDLE;
			remaining <= '0;
			fcs_seen  <= 1'b0;
			cap_valid <= 1'b0;
			cap_last  <= 1'b0;
		end
		else
		begin
			cap_valid <= take;
			cap_last  <= take && (remaining == CAP_LEN_W'(1));
			case (state)
				CAP_IDLE:
				begin
					// zero length arms nothing
					if (cfg.arm && (cfg.cap_len != '0))
					begin
						state     <= CAP_ARMED;
						remaining <= cfg.cap_len;
						fcs_seen  <= 1'b0;
					end
				end
				CAP_ARMED:
				begin
					if (fcs_in_strobe && fcs_ok)
						fcs_seen <= 1'b1;
				end
				CAP_RUN:  ;
				default:  state <= CAP_IDLE;
			endcase
			if (take)
			begin
				remaining <= remaining - CAP_LEN_W'(1);
				state     <= (remaining == CAP_LEN_W'(1)) ? CAP_IDLE : CAP_RUN;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (take)
			cap_word <= {s1_sw.raw, s0_sw.raw};
	end

endmodule

// File: src/side_ch_event_counters.sv
// side channel event source selection feeding six clearable event counters
`timescale 1ns/1ps

module side_ch_event_counters import side_ch_pkg::*;
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     short_preamble_detected,
	input  logic                     long_preamble_detected,
	input  logic                     pkt_header_valid_strobe,
	input  logic                     pkt_header_valid,
	input  logic                     fcs_in_strobe,
	input  logic                     fcs_ok,
	input  logic                     phy_tx_start,
	input  logic                     phy_tx_done,
	input  logic                     tx_pkt_need_ack,
	input  logic                     pkt_for_me,
	input  logic [ADDR2_W-1:0]       addr2,
	input  logic signed [RSSI_W-1:0] rssi_half_db,
	output counter_arr_t             counters,
	side_ch_cfg_if.counters          cfg
);

	logic                  fcs_good;
	logic                  addr2_match;
	logic                  rssi_above;
	logic                  rssi_above_d;
	logic                  rssi_cross;
	logic [NUM_EVENTS-1:0] ev;

	assign fcs_good    = fcs_in_strobe && fcs_ok;
	assign addr2_match = (addr2[REG_DATA_W-1:0] == cfg.addr2_target);
	assign rssi_above  = (rssi_half_db > cfg.rssi_th);
	// a level above threshold counts once on its rising edge
	assign rssi_cross  = rssi_above && !rssi_above_d;

	// select bit low picks the first source
	always_comb
	begin
		ev[0] = cfg.event_sel[0] ? long_preamble_detected : short_preamble_detected;
		ev[1] = pkt_header_valid_strobe &&
			(cfg.event_sel[1] ? !pkt_header_valid : pkt_header_valid);
		ev[2] = fcs_in_strobe && (cfg.event_sel[2] ? !fcs_ok : fcs_ok);
		ev[3] = cfg.event_sel[3] ? phy_tx_done : phy_tx_start;
		ev[4] = fcs_good && (cfg.event_sel[4] ? pkt_for_me : addr2_match);
		ev[5] = cfg.event_sel[5] ? (phy_tx_start && tx_pkt_need_ack) : rssi_cross;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			rssi_above_d <= 1'b0;
		else
			rssi_above_d <= rssi_above;
	end

	// clear beats a same cycle event and counts wrap
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			counters <= '0;
		end
		else
		begin
			for (int i = 0; i < NUM_EVENTS; i++)
			begin
				if (cfg.counter_clr[i])
					counters[i] <= '0;
				else if (ev[i])
					counters[i] <= counters[i] + COUNTER_W'(1);
			end
		end
	end

endmodule

// File: src/side_ch_reg_bank.sv
// side channel register bank with config writes, control pulses and registered readback
`timescale 1ns/1ps

module side_ch_reg_bank import side_ch_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  reg_wr,
	input  logic                  reg_rd,
	input  logic [REG_ADDR_W-1:0] reg_addr,
	input  logic [REG_DATA_W-1:0] reg_wdata,
	input  counter_arr_t          counters,
	input  logic [REG_DATA_W-1:0] drop_cnt,
	output logic [REG_DATA_W-1:0] reg_rdata,
	output logic                  reg_rvalid,
	side_ch_cfg_if.bank           cfg
);

	logic [NUM_EVENTS-1:0] clr_next;
	logic [REG_DATA_W-1:0] rd_next;

	// a write to a counter address clears that counter
	always_comb
	begin
		for (int i = 0; i < NUM_EVENTS; i++)
		begin
			clr_next[i] = reg_wr && (reg_addr == REG_ADDR_W'(REG_CNT_BASE + i));
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cfg.trig_sel     <= '0;
			cfg.rssi_th      <= '0;
			cfg.cap_len      <= '0;
			cfg.event_sel    <= '0;
			cfg.addr2_target <= '0;
			cfg.arm          <= 1'b0;
			cfg.counter_clr  <= '0;
		end
		else
		begin
			cfg.arm         <= reg_wr && (reg_addr == REG_ARM);
			cfg.counter_clr <= clr_next;
			if (reg_wr)
			begin
				case (reg_addr)
					REG_TRIG_SEL:     cfg.trig_sel     <= reg_wdata[TRIG_W-1:0];
					REG_RSSI_TH:      cfg.rssi_th      <= $signed(reg_wdata[RSSI_W-1:0]);
					REG_CAP_LEN:      cfg.cap_len      <= reg_wdata[CAP_LEN_W-1:0];
					REG_EVENT_SEL:    cfg.event_sel    <= reg_wdata[NUM_EVENTS-1:0];
					REG_ADDR2_TARGET: cfg.addr2_target <= reg_wdata;
					default:          ;
				endcase
			end
		end
	end

	// unmapped and write-only addresses read as zero
	always_comb
	begin
		rd_next = '0;
		case (reg_addr)
			REG_TRIG_SEL:     rd_next = REG_DATA_W'(cfg.trig_sel);
			REG_RSSI_TH:      rd_next = {{(REG_DATA_W-RSSI_W){1'b0}}, cfg.rssi_th};
			REG_CAP_LEN:      rd_next = REG_DATA_W'(cfg.cap_len);
			REG_EVENT_SEL:    rd_next = REG_DATA_W'(cfg.event_sel);
			REG_ADDR2_TARGET: rd_next = cfg.addr2_target;
			REG_DROP_CNT:     rd_next = drop_cnt;
			default:          rd_next = '0;
		endcase
		for (int i = 0; i < NUM_EVENTS; i++)
		begin
			if (reg_addr == REG_ADDR_W'(REG_CNT_BASE + i))
				rd_next = REG_DATA_W'(counters[i]);
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			reg_rvalid <= 1'b0;
			reg_rdata  <= '0;
		end
		else
		begin
			reg_rvalid <= reg_rd;
			if (reg_rd)
				reg_rdata <= rd_next;
		end
	end

endmodule

// File: src/side_ch_cfg_if.sv
// side channel configuration bundle from the register bank to counters and capture
`timescale 1ns/1ps

interface side_ch_cfg_if import side_ch_pkg::*; ();

	logic [TRIG_W-1:0]        trig_sel;
	logic signed [RSSI_W-1:0] rssi_th;
	logic [CAP_LEN_W-1:0]     cap_len;
	logic [NUM_EVENTS-1:0]    event_sel;
	logic [REG_DATA_W-1:0]    addr2_target;
	// single cycle pulses
	logic                     arm;
	logic [NUM_EVENTS-1:0]    counter_clr;

	modport bank (
		output trig_sel, rssi_th, cap_len, event_sel, addr2_target, arm, counter_clr
	);

	modport counters (
		input event_sel, addr2_target, rssi_th, counter_clr
	);

	modport capture (
		input trig_sel, rssi_th, cap_len, arm
	);

endinterface

// File: src/side_ch_pkg.sv
// side channel package with widths, register map, trigger codes and shared types
package side_ch_pkg;

	// register port
	localparam int REG_DATA_W = 32;
	localparam int REG_ADDR_W = 4;

	localparam logic [REG_ADDR_W-1:0] REG_TRIG_SEL     = 4'd0;
	localparam logic [REG_ADDR_W-1:0] REG_RSSI_TH      = 4'd1;
	localparam logic [REG_ADDR_W-1:0] REG_CAP_LEN      = 4'd2;
	localparam logic [REG_ADDR_W-1:0] REG_EVENT_SEL    = 4'd3;
	localparam logic [REG_ADDR_W-1:0] REG_ADDR2_TARGET = 4'd4;
	localparam logic [REG_ADDR_W-1:0] REG_ARM          = 4'd5;
	// counters 0..5 sit at 8..13
	localparam logic [REG_ADDR_W-1:0] REG_CNT_BASE     = 4'd8;
	localparam logic [REG_ADDR_W-1:0] REG_DROP_CNT     = 4'd14;

	// event counters
	localparam int NUM_EVENTS = 6;
	localparam int COUNTER_W  = 16;
	localparam int RSSI_W     = 11;
	localparam int ADDR2_W    = 48;

	// iq capture
	localparam int IQ_W      = 16;
	localparam int CAP_LEN_W = 8;
	localparam int TRIG_W    = 2;

	localparam logic [TRIG_W-1:0] TRIG_FREE_RUN = 2'd0;
	localparam logic [TRIG_W-1:0] TRIG_RSSI     = 2'd1;
	localparam logic [TRIG_W-1:0] TRIG_FCS_OK   = 2'd2;

	// capture fsm encoding
	localparam int CAP_STATE_W = 2;
	localparam logic [CAP_STATE_W-1:0] CAP_IDLE  = 2'd0;
	localparam logic [CAP_STATE_W-1:0] CAP_ARMED = 2'd1;
	localparam logic [CAP_STATE_W-1:0] CAP_RUN   = 2'd2;

	// output fifo and stream
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW    = 4;
	localparam int STREAM_W   = 64;

	// one channel word, seen whole or as its two halves
	typedef union packed {
		logic [2*IQ_W-1:0] raw;
		struct packed {
			logic [IQ_W-1:0] hi;
			logic [IQ_W-1:0] lo;
		} part;
	} iq_sample_u;

	typedef logic [NUM_EVENTS-1:0][COUNTER_W-1:0] counter_arr_t;

endpackage
